/* filelist.f */
+incdir+.
merge_pkg.sv
block_fifo.sv
merge_control.sv
merge_datapath.sv
block_merger.sv
tb_block_merger.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_block_merger
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := RESULT: PASS

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_block_merger.sv */
`timescale 1ns/1ns
`default_nettype none

`include "merge_config.svh"

module tb_block_merger
   import merge_pkg::*;
();

   localparam int REC            = `MRG_REC_PER_BLK;
   localparam int CYCLES_PER_BLK = 40;

   logic   i_clk;
   logic   i_rst_n;
   block_t i_a_data;
   logic   i_a_empty;
   logic   o_a_read;
   block_t i_b_data;
   logic   i_b_empty;
   logic   o_b_read;
   block_t o_out_data;
   logic   o_out_write;
   logic   i_out_ready;

   block_t      a_q[$];     // Upstream A, head at index 0.
   block_t      b_q[$];
   block_t      exp_q[$];   // Reference blocks still to come.
   logic [31:0] rng_state = 32'hf17bea75;
   logic        gap_on;
   logic        ready_rand;
   int          out_count;
   int          last_count;
   int          cycle;
   int          wd_deadline;

   block_merger block_merger_i (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_data    (i_a_data),
      .i_a_empty   (i_a_empty),
      .o_a_read    (o_a_read),
      .i_b_data    (i_b_data),
      .i_b_empty   (i_b_empty),
      .o_b_read    (o_b_read),
      .o_out_data  (o_out_data),
      .o_out_write (o_out_write),
      .i_out_ready (i_out_ready)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic int rand_below(input int n);
      return int'(next_rand() % 32'(n));
   endfunction

   // Value depends on the key only, so ties need no ordering.
   function automatic logic [`MRG_VAL_W-1:0] val_of(input logic [`MRG_KEY_W-1:0] k);
      return `MRG_VAL_W'(k * 16'h9e37) ^ `MRG_VAL_W'(16'h5a5a);
   endfunction

   // Sorts all records of both streams and cuts them into blocks.
   function automatic void ref_merge(input block_t sa[$], input block_t sb[$]);
      record_t recs[$];
      record_t tmp;
      block_t  blk;
      int      j;
      int      nblk;
      foreach (sa[i]) begin
         for (int r = 0; r < REC; r++) recs.push_back(sa[i].rec[r]);
      end
      foreach (sb[i]) begin
         for (int r = 0; r < REC; r++) recs.push_back(sb[i].rec[r]);
      end
      for (int i = 1; i < recs.size(); i++) begin
         tmp = recs[i];
         j   = i - 1;
         while (j >= 0 && recs[j].key > tmp.key) begin
            recs[j + 1] = recs[j];
            j--;
         end
         recs[j + 1] = tmp;
      end
      nblk = recs.size() / REC;
      for (int b = 0; b < nblk; b++) begin
         for (int r = 0; r < REC; r++) blk.rec[r] = recs[b * REC + r];
         blk.last = (b == nblk - 1);
         exp_q.push_back(blk);
      end
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped on the first error.");
   endtask

   task automatic check_block(input block_t got, input block_t exp);
      if (got !== exp) begin
         $display("ERROR: time %0t o_out_data got %h expected %h", $time, got, exp);
         stop_with_failure("Output block differs from the reference merge");
      end
   endtask

   task automatic check_count(input int got, input int exp);
      if (got != exp) begin
         $display("ERROR: time %0t block count got %0d expected %0d", $time, got, exp);
         stop_with_failure("Wrong number of output blocks for a stream pair");
      end
   endtask

   // Nondecreasing keys, four to a block, last flag on the final one.
   task automatic gen_stream(input int nblk, input int start, input int step, input bit to_a);
      block_t blk;
      int     key;
      key = start;
      for (int b = 0; b < nblk; b++) begin
         for (int r = 0; r < REC; r++) begin
            key            = key + rand_below(step);
            blk.rec[r].key = `MRG_KEY_W'(key);
            blk.rec[r].val = val_of(blk.rec[r].key);
         end
         blk.last = (b == nblk - 1);
         if (to_a) begin
            a_q.push_back(blk);
         end else begin
            b_q.push_back(blk);
         end
      end
   endtask

   task automatic run_pair(input int na, input int nb, input int a_start,
                           input int b_start, input int step);
      int n_exp;
      int base;
      int lasts;
      base  = out_count;
      lasts = last_count;
      gen_stream(na, a_start, step, 1'b1);
      gen_stream(nb, b_start, step, 1'b0);
      ref_merge(a_q, b_q);
      n_exp       = na + nb;
      wd_deadline = cycle + CYCLES_PER_BLK * n_exp;
      wait (last_count != lasts);
      check_count(out_count - base, n_exp);
   endtask

   initial begin : clock_gen
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   // Upstream FIFOs and downstream ready, all changed 1 ns after the edge.
   initial begin : drive_inputs
      logic take_a;
      logic take_b;
      i_a_data    = '0;
      i_a_empty   = 1'b1;
      i_b_data    = '0;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b0;
      forever begin
         @(negedge i_clk);
         take_a = o_a_read;
         take_b = o_b_read;
         if (take_a && i_a_empty) begin
            stop_with_failure("o_a_read was raised while upstream A was empty");
         end
         if (take_b && i_b_empty) begin
            stop_with_failure("o_b_read was raised while upstream B was empty");
         end
         @(posedge i_clk);
         #1;
         if (take_a) void'(a_q.pop_front());
         if (take_b) void'(b_q.pop_front());
         i_a_empty   = (a_q.size() == 0) || (gap_on && rand_below(4) == 0);
         i_b_empty   = (b_q.size() == 0) || (gap_on && rand_below(4) == 0);
         i_a_data    = (a_q.size() != 0) ? a_q[0] : '0;
         i_b_data    = (b_q.size() != 0) ? b_q[0] : '0;
         i_out_ready = !ready_rand || (rand_below(3) != 0);
      end
   end

   initial begin : compare
      block_t expected;
      out_count  = 0;
      last_count = 0;
      forever begin
         @(negedge i_clk);
         if (i_rst_n === 1'b1 && o_out_write === 1'b1) begin
            if (i_out_ready !== 1'b1) begin
               stop_with_failure("o_out_write was raised while i_out_ready was low");
            end else if (exp_q.size() == 0) begin
               stop_with_failure("Output block written while no block was expected");
            end else begin
               expected = exp_q.pop_front();
               check_block(o_out_data, expected);
               out_count++;
               if (o_out_data.last) last_count++;
            end
         end
      end
   end

   initial begin : watchdog
      cycle = 0;
      forever begin
         @(posedge i_clk);
         cycle++;
         if (cycle > wd_deadline) begin
            stop_with_failure($sformatf(
               "Watchdog expired at cycle %0d before the stream pair finished", cycle));
         end
      end
   end

   initial begin : main
      int len;
      i_rst_n     = 1'b0;
      gap_on      = 1'b0;
      ready_rand  = 1'b0;
      wd_deadline = 10 + CYCLES_PER_BLK;
      repeat (10) @(posedge i_clk);
      #1;
      i_rst_n = 1'b1;
      @(negedge i_clk);

      // Equal lengths, steady upstream and downstream.
      for (int p = 0; p < 3; p++) begin
         len = 2 + rand_below(6);
         run_pair(len, len, rand_below(500), rand_below(500), 40);
      end

      // Unequal lengths and fully separated key ranges.
      run_pair(1, 6, rand_below(300), rand_below(300), 30);
      run_pair(7, 2, rand_below(300), rand_below(300), 30);
      run_pair(5, 3, 0, 30000, 20);
      run_pair(2, 6, 40000, 10, 20);

      ready_rand = 1'b1;
      run_pair(6, 9, rand_below(500), rand_below(500), 30);
      run_pair(10, 4, rand_below(500), rand_below(500), 30);

      ready_rand = 1'b0;
      gap_on     = 1'b1;
      run_pair(8, 5, rand_below(500), rand_below(500), 30);
      run_pair(4, 4, rand_below(500), rand_below(500), 30);

      // Many equal keys on both sides.
      ready_rand = 1'b1;
      run_pair(6, 6, 100, 100, 2);
      run_pair(3, 7, 100, 101, 2);

      // Pairs back to back, each relying on the flush to re-arm.
      for (int p = 0; p < 10; p++) begin
         gap_on     = (rand_below(2) == 0);
         ready_rand = (rand_below(2) == 0);
         run_pair(1 + rand_below(6), 1 + rand_below(6), rand_below(1000), rand_below(1000),
                  1 + rand_below(25));
      end

      wd_deadline = cycle + CYCLES_PER_BLK;
      repeat (20) @(negedge i_clk);
      if (exp_q.size() == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         stop_with_failure("Expected output blocks never appeared");
      end
   end

endmodule

`default_nettype wire

/* block_merger.sv */
`timescale 1ns/1ns
`default_nettype none

`include "merge_config.svh"

module block_merger
   import merge_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_rst_n,
   input  block_t i_a_data,
   input  logic   i_a_empty,
   output logic   o_a_read,
   input  block_t i_b_data,
   input  logic   i_b_empty,
   output logic   o_b_read,
   output block_t o_out_data,
   output logic   o_out_write,
   input  logic   i_out_ready
);

   block_t a_head;
   block_t b_head;
   logic   a_empty;
   logic   a_full;
   logic   b_empty;
   logic   b_full;
   logic   pop_a;
   logic   pop_b;
   sel_t   sel;
   logic   dp_write;
   block_t dp_blk;
   logic   out_empty;
   logic   out_nearly_full;

   // Upstream pops in the same cycle the input FIFO takes the block.
   assign o_a_read    = !i_a_empty && !a_full;
   assign o_b_read    = !i_b_empty && !b_full;
   assign o_out_write = i_out_ready && !out_empty;

   block_fifo #(.DEPTH(`MRG_IN_DEPTH)) fifo_a (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_push        (o_a_read),
      .i_data        (i_a_data),
      .i_pop         (pop_a),
      .o_data        (a_head),
      .o_empty       (a_empty),
      .o_full        (a_full),
      .o_nearly_full ()
   );

   block_fifo #(.DEPTH(`MRG_IN_DEPTH)) fifo_b (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_push        (o_b_read),
      .i_data        (i_b_data),
      .i_pop         (pop_b),
      .o_data        (b_head),
      .o_empty       (b_empty),
      .o_full        (b_full),
      .o_nearly_full ()
   );

   merge_control merge_control_i (
      .i_clk             (i_clk),
      .i_rst_n           (i_rst_n),
      .i_a_empty         (a_empty),
      .i_a_key0          (a_head.rec[0].key),
      .i_a_last          (a_head.last),
      .i_b_empty         (b_empty),
      .i_b_key0          (b_head.rec[0].key),
      .i_b_last          (b_head.last),
      .i_out_nearly_full (out_nearly_full),
      .o_sel             (sel),
      .o_pop_a           (pop_a),
      .o_pop_b           (pop_b)
   );

   merge_datapath merge_datapath_i (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_sel       (sel),
      .i_a_blk     (a_head),
      .i_b_blk     (b_head),
      .o_out_write (dp_write),
      .o_out_blk   (dp_blk)
   );

   block_fifo #(.DEPTH(`MRG_OUT_DEPTH)) fifo_out (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_push        (dp_write),
      .i_data        (dp_blk),
      .i_pop         (o_out_write),
      .o_data        (o_out_data),
      .o_empty       (out_empty),
      .o_full        (),
      .o_nearly_full (out_nearly_full)
   );

endmodule

`default_nettype wire

/* merge_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

`include "merge_config.svh"

module merge_datapath
   import merge_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_rst_n,
   input  sel_t   i_sel,
   input  block_t i_a_blk,
   input  block_t i_b_blk,
   output logic   o_out_write,
   output block_t o_out_blk
);

   localparam int REC    = `MRG_REC_PER_BLK;
   localparam int N      = 2 * REC;
   localparam int LEVELS = $clog2(N);

   block_t              in_blk;
   record_t [REC-1:0]   ret;       // Retained upper half, ascending.
   logic                ret_valid;
   record_t             net [LEVELS+1][N];
   record_t [REC-1:0]   lo_recs;
   record_t [REC-1:0]   hi_recs;

   assign in_blk = (i_sel == SEL_B) ? i_b_blk : i_a_blk;

   // Bitonic merge of the incoming block and the retained half.
   always_comb begin
      int d;
      int lo;
      int hi;
      // Ascending block, then retained half reversed.
      for (int i = 0; i < REC; i++) begin
         net[0][i]         = in_blk.rec[i];
         net[0][N - 1 - i] = ret[i];
      end
      for (int l = 0; l < LEVELS; l++) begin
         d = N >> (l + 1);
         for (int j = 0; j < N / 2; j++) begin
            lo = (j / d) * 2 * d + (j % d);
            hi = lo + d;
            if (net[l][lo].key > net[l][hi].key) begin
               net[l+1][lo] = net[l][hi];
               net[l+1][hi] = net[l][lo];
            end else begin
               net[l+1][lo] = net[l][lo];
               net[l+1][hi] = net[l][hi];
            end
         end
      end
      for (int i = 0; i < REC; i++) begin
         lo_recs[i] = net[LEVELS][i];
         hi_recs[i] = net[LEVELS][REC + i];
      end
   end

   // Control state.
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ret_valid   <= 1'b0;
         o_out_write <= 1'b0;
      end else begin
         o_out_write <= 1'b0;
         case (i_sel)
            SEL_A, SEL_B: begin
               if (ret_valid) begin
                  o_out_write <= 1'b1;
               end else begin
                  ret_valid <= 1'b1;  // First block only primes the half.
               end
            end
            SEL_FLUSH: begin
               o_out_write <= 1'b1;
               ret_valid   <= 1'b0;
            end
            default: ret_valid <= ret_valid;
         endcase
      end
   end

   // Payload registers.
   always_ff @(posedge i_clk) begin
      case (i_sel)
         SEL_A, SEL_B: begin
            if (ret_valid) begin
               ret            <= hi_recs;
               o_out_blk.rec  <= lo_recs;
               o_out_blk.last <= 1'b0;
            end else begin
               ret <= in_blk.rec;
            end
         end
         SEL_FLUSH: begin
            o_out_blk.rec  <= ret;
            o_out_blk.last <= 1'b1;  // Closes the merged stream.
         end
         default: ret <= ret;
      endcase
   end

   a_flush_has_half : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) (i_sel == SEL_FLUSH) |-> ret_valid
   ) else $error("merge_datapath: flush without a retained half");

endmodule

`default_nettype wire

/* merge_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "merge_config.svh"

module merge_control
   import merge_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_a_empty,
   input  logic [`MRG_KEY_W-1:0] i_a_key0,
   input  logic                  i_a_last,
   input  logic                  i_b_empty,
   input  logic [`MRG_KEY_W-1:0] i_b_key0,
   input  logic                  i_b_last,
   input  logic                  i_out_nearly_full,
   output sel_t                  o_sel,
   output logic                  o_pop_a,
   output logic                  o_pop_b
);

   logic a_done;  // Last block of A already selected.
   logic b_done;

   // Selection is combinational on the FIFO heads.
   always_comb begin
      o_sel = SEL_NONE;
      if (!i_out_nearly_full) begin
         if (a_done && b_done) begin
            o_sel = SEL_FLUSH;
         end else if (!a_done && !b_done) begin
            // Both live, so both heads are needed for the compare.
            if (!i_a_empty && !i_b_empty) begin
               o_sel = (i_a_key0 <= i_b_key0) ? SEL_A : SEL_B;
            end
         end else if (!a_done) begin
            if (!i_a_empty) begin
               o_sel = SEL_A;
            end
         end else if (!i_b_empty) begin
            o_sel = SEL_B;
         end
      end
   end

   assign o_pop_a = (o_sel == SEL_A);
   assign o_pop_b = (o_sel == SEL_B);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         a_done <= 1'b0;
         b_done <= 1'b0;
      end else begin
         case (o_sel)
            SEL_A: begin
               if (i_a_last) begin
                  a_done <= 1'b1;
               end
            end
            SEL_B: begin
               if (i_b_last) begin
                  b_done <= 1'b1;
               end
            end
            SEL_FLUSH: begin
               a_done <= 1'b0;  // Re-arm for the next pair.
               b_done <= 1'b0;
            end
            default: begin
               a_done <= a_done;
               b_done <= b_done;
            end
         endcase
      end
   end

   a_pop_a_valid : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) o_pop_a |-> !i_a_empty
   ) else $error("merge_control: pop on empty FIFO A");

   a_pop_b_valid : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) o_pop_b |-> !i_b_empty
   ) else $error("merge_control: pop on empty FIFO B");

endmodule

`default_nettype wire

/* block_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module block_fifo
   import merge_pkg::*;
#(
   parameter int DEPTH = 8
) (
   input  logic   i_clk,
   input  logic   i_rst_n,
   input  logic   i_push,
   input  block_t i_data,
   input  logic   i_pop,
   output block_t o_data,
   output logic   o_empty,
   output logic   o_full,
   output logic   o_nearly_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   block_t           mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (i_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({i_push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Block storage.
   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   assign o_data        = mem[rd_ptr];  // Head shows without a pop.
   assign o_empty       = (count == '0);
   assign o_full        = (count == CNT_W'(DEPTH));
   assign o_nearly_full = (count >= CNT_W'((DEPTH > 2) ? DEPTH - 2 : 0));  // Two or fewer free.

   a_no_overflow : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full
   ) else $error("block_fifo: push while full");

   a_no_underflow : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) i_pop |-> !o_empty
   ) else $error("block_fifo: pop while empty");

endmodule

`default_nettype wire

/* merge_pkg.sv */
`default_nettype none

`include "merge_config.svh"

package merge_pkg;

   // One key/value pair, key in the upper bits.
   typedef struct packed {
      logic [`MRG_KEY_W-1:0] key;
      logic [`MRG_VAL_W-1:0] val;
   } record_t;

   // Sorted block of records. Element 0 holds the smallest key.
   typedef struct packed {
      logic                              last;  // Final block of a stream.
      record_t [`MRG_REC_PER_BLK-1:0]    rec;
   } block_t;

   // Datapath operation chosen by control each cycle.
   typedef enum logic [1:0] {
      SEL_NONE  = 2'd0,
      SEL_A     = 2'd1,
      SEL_B     = 2'd2,
      SEL_FLUSH = 2'd3
   } sel_t;

endpackage

`default_nettype wire

/* merge_config.svh */
`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// Record fields.
`define MRG_KEY_W 16
`define MRG_VAL_W 16

// Records per block. The merge network is twice this wide.
`define MRG_REC_PER_BLK 4

// FIFO depths in blocks.
`define MRG_IN_DEPTH 8
`define MRG_OUT_DEPTH 8

`endif
